// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/alu.sv
      - rtl/instr_decoder.sv
      - rtl/hazard_unit.sv
      - rtl/fetch_stage.sv
      - rtl/decode_stage.sv
      - rtl/execute_stage.sv
      - rtl/mem_wb_stage.sv
      - rtl/riscv_core.sv
  - target: test
    files:
      - verification/tb_riscv_core.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu import core_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_fn_e         fn,
  output logic [XLEN-1:0] y
);

  always_comb begin
    unique case (fn)
      ALU_ADD:  y = a + b;
      ALU_SUB:  y = a - b;
      ALU_AND:  y = a & b;
      ALU_OR:   y = a | b;
      ALU_XOR:  y = a ^ b;
      ALU_SLT:  y = XLEN'($signed(a) < $signed(b));
      ALU_SLTU: y = XLEN'(a < b);
      default:  y = '0;
    endcase
  end

  // the decoder and the bubble path only ever hand over the seven codes
  fn_defined: assert final ($isunknown(fn) ||
                            fn inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                                       ALU_XOR, ALU_SLT, ALU_SLTU})
    else $error("alu: undefined function code %0d", fn);

endmodule

// ==== rtl/core_pkg.sv ====
package core_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  localparam logic [REG_AW-1:0] ZERO_REG = '0;

  typedef enum logic [6:0] {
    OP_REG   = 7'b0110011,
    OP_IMM   = 7'b0010011,
    OP_LUI   = 7'b0110111,
    OP_LOAD  = 7'b0000011,
    OP_STORE = 7'b0100011
  } op_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6
  } alu_fn_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_src_e;

  // bypass source for an execute operand
  typedef enum logic [1:0] {
    FWD_REG    = 2'd0,
    FWD_EX_MEM = 2'd1,
    FWD_MEM_WB = 2'd2
  } fwd_sel_e;

  // instruction word views
  typedef struct packed {
    logic [6:0]        funct7;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]       imm;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]        imm_hi;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rs1;
    logic [2:0]        funct3;
    logic [4:0]        imm_lo;
    logic [6:0]        opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0]       imm;
    logic [REG_AW-1:0] rd;
    logic [6:0]        opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  typedef struct packed {
    alu_fn_e alu_fn;
    logic    use_imm;   // operand b is the immediate
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    wb_src_e wb_src;
  } ctrl_t;

  typedef struct packed {
    logic              valid;
    ctrl_t             ctrl;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   imm;
  } id_ex_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs2;        // kept for the load-to-store fixup
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    wb_src_e           wb_src;
    logic [XLEN-1:0]   alu_out;    // result or memory address
    logic [XLEN-1:0]   store_data;
  } ex_mem_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    logic              reg_write;
    wb_src_e           wb_src;
    logic [XLEN-1:0]   alu_out;
    logic [XLEN-1:0]   load_data;
  } mem_wb_t;

  // writeback bus, also the MEM/WB bypass source
  typedef struct packed {
    logic              we;
    logic [REG_AW-1:0] addr;
    logic [XLEN-1:0]   data;
  } wb_t;

  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import core_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  input  logic              stall,
  input  instr_u            if_instr,
  input  logic              if_valid,
  input  logic [XLEN-1:0]   rf_rd1,
  input  logic [XLEN-1:0]   rf_rd2,
  output logic [REG_AW-1:0] rf_ra1,
  output logic [REG_AW-1:0] rf_ra2,
  output logic [REG_AW-1:0] rs1,
  output logic [REG_AW-1:0] rs2,
  output logic              uses_rs2,
  output id_ex_t            id_ex
);

  ctrl_t             dec_ctrl;
  logic [REG_AW-1:0] dec_rd;
  logic              dec_uses_rs2;
  logic [XLEN-1:0]   imm;
  id_ex_t            id_ex_d;

  instr_decoder u_dec (
    .instr    (if_instr),
    .ctrl     (dec_ctrl),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (dec_rd),
    .uses_rs2 (dec_uses_rs2)
  );

  assign rf_ra1   = rs1;
  assign rf_ra2   = rs2;
  assign uses_rs2 = dec_uses_rs2 && !dec_ctrl.mem_write;  // store data needed only in memory

  always_comb begin
    unique case (if_instr.i_fmt.opcode)
      OP_STORE: imm = {{(XLEN-12){if_instr.s_fmt.imm_hi[6]}},
                       if_instr.s_fmt.imm_hi, if_instr.s_fmt.imm_lo};
      OP_LUI:   imm = {if_instr.u_fmt.imm, 12'b0};
      default:  imm = {{(XLEN-12){if_instr.i_fmt.imm[11]}}, if_instr.i_fmt.imm};
    endcase
  end

  always_comb begin
    id_ex_d          = '{default: '0};
    id_ex_d.valid    = if_valid && !stall;  // bubble while the load moves on
    id_ex_d.ctrl     = dec_ctrl;
    id_ex_d.rd       = dec_rd;
    id_ex_d.rs1      = rs1;
    id_ex_d.rs2      = rs2;
    id_ex_d.rs1_data = rf_rd1;
    id_ex_d.rs2_data = rf_rd2;
    id_ex_d.imm      = imm;
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
      id_ex.ctrl  <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import core_pkg::*; (
  input  logic     CLK,
  input  logic     rst_n,
  input  id_ex_t   id_ex,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  ex_mem_t  ex_mem_in,   // current EX/MEM, bypass source
  input  wb_t      wb,
  output ex_mem_t  ex_mem
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_y;

  function automatic logic [XLEN-1:0] bypass(input fwd_sel_e sel,
                                             input logic [XLEN-1:0] reg_val);
    unique case (sel)
      FWD_EX_MEM: return ex_mem_in.alu_out;
      FWD_MEM_WB: return wb.data;
      default:    return reg_val;
    endcase
  endfunction

  always_comb begin
    op_a    = bypass(fwd_a, id_ex.rs1_data);
    rs2_val = bypass(fwd_b, id_ex.rs2_data);
    op_b    = id_ex.ctrl.use_imm ? id_ex.imm : rs2_val;
  end

  alu u_alu (
    .a  (op_a),
    .b  (op_b),
    .fn (id_ex.ctrl.alu_fn),
    .y  (alu_y)
  );

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.rd         <= id_ex.rd;
      ex_mem.rs2        <= id_ex.rs2;
      ex_mem.mem_read   <= id_ex.ctrl.mem_read;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.wb_src     <= id_ex.ctrl.wb_src;
      ex_mem.alu_out    <= alu_y;      // address for loads and stores
      ex_mem.store_data <= rs2_val;
    end
  end

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import core_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            stall,
  input  logic [XLEN-1:0] imem_data,
  output logic [XLEN-1:0] imem_addr,
  output instr_u          if_instr,
  output logic            if_valid
);

  logic [XLEN-1:0] pc;

  assign imem_addr = pc;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pc       <= '0;
      if_instr <= NOP_INSTR;
      if_valid <= 1'b0;
    end else if (!stall) begin   // hold pc and IF/ID on a load-use stall
      pc       <= pc + XLEN'(4);
      if_instr <= imem_data;
      if_valid <= 1'b1;
    end
  end

  pc_aligned: assert property (@(posedge CLK) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("fetch: pc %h not word aligned", pc);

  // the bubble put into ID/EX clears the hazard on the next cycle
  stall_one_cycle: assert property (@(posedge CLK) disable iff (!rst_n) stall |=> !stall)
    else $error("fetch: stall held for more than one cycle");

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit import core_pkg::*; (
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  input  logic              uses_rs2,   // low for stores, their data is patched in memory
  input  id_ex_t            id_ex,
  input  ex_mem_t           ex_mem,
  input  wb_t               wb,
  output logic              stall,
  output fwd_sel_e          fwd_a,
  output fwd_sel_e          fwd_b,
  output logic              store_fwd
);

  logic load_in_ex;

  function automatic fwd_sel_e pick_src(input logic [REG_AW-1:0] src);
    if (ex_mem.valid && ex_mem.reg_write && ex_mem.rd != ZERO_REG && ex_mem.rd == src)
      return FWD_EX_MEM;   // youngest producer wins
    else if (wb.we && wb.addr != ZERO_REG && wb.addr == src)
      return FWD_MEM_WB;
    else
      return FWD_REG;
  endfunction

  always_comb begin
    fwd_a = pick_src(id_ex.rs1);
    fwd_b = pick_src(id_ex.rs2);
  end

  assign load_in_ex = id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != ZERO_REG;

  assign stall = load_in_ex &&
                 (id_ex.rd == rs1 || (uses_rs2 && id_ex.rd == rs2));

  // load directly ahead of a store that writes the loaded register
  assign store_fwd = ex_mem.valid && ex_mem.mem_write &&
                     wb.we && wb.addr != ZERO_REG && wb.addr == ex_mem.rs2;

  // a stalling load must be one the decoder marked as writing a register
  stall_on_load: assert final (stall !== 1'b1 ||
                               (id_ex.valid && id_ex.ctrl.mem_read && id_ex.ctrl.reg_write))
    else $error("hazard: stall without a valid load in execute");

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder import core_pkg::*; (
  input  instr_u            instr,
  output ctrl_t             ctrl,
  output logic [REG_AW-1:0] rs1,
  output logic [REG_AW-1:0] rs2,
  output logic [REG_AW-1:0] rd,
  output logic              uses_rs2
);

  logic writes_rd;

  assign rd = instr.r_fmt.rd;

  always_comb begin
    ctrl      = '0;               // unknown encodings fall out as a bubble
    ctrl.alu_fn = ALU_ADD;
    ctrl.wb_src = WB_ALU;
    writes_rd = 1'b0;
    uses_rs2  = 1'b0;
    rs1       = ZERO_REG;         // unused sources read x0, so they never match
    unique case (instr.r_fmt.opcode)
      OP_REG: begin
        rs1       = instr.r_fmt.rs1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
        unique case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
          10'b0000000_000: ctrl.alu_fn = ALU_ADD;
          10'b0100000_000: ctrl.alu_fn = ALU_SUB;
          10'b0000000_111: ctrl.alu_fn = ALU_AND;
          10'b0000000_110: ctrl.alu_fn = ALU_OR;
          10'b0000000_100: ctrl.alu_fn = ALU_XOR;
          10'b0000000_010: ctrl.alu_fn = ALU_SLT;
          10'b0000000_011: ctrl.alu_fn = ALU_SLTU;
          default:         writes_rd = 1'b0;
        endcase
      end
      OP_IMM: begin
        rs1          = instr.i_fmt.rs1;
        ctrl.use_imm = 1'b1;
        writes_rd    = 1'b1;
        unique case (instr.i_fmt.funct3)
          3'b000:  ctrl.alu_fn = ALU_ADD;
          3'b111:  ctrl.alu_fn = ALU_AND;
          3'b110:  ctrl.alu_fn = ALU_OR;
          3'b100:  ctrl.alu_fn = ALU_XOR;
          3'b010:  ctrl.alu_fn = ALU_SLT;
          default: writes_rd = 1'b0;
        endcase
      end
      OP_LUI: begin
        ctrl.use_imm = 1'b1;      // x0 + (imm << 12)
        writes_rd    = 1'b1;
      end
      OP_LOAD: begin
        if (instr.i_fmt.funct3 == 3'b010) begin
          rs1           = instr.i_fmt.rs1;
          ctrl.use_imm  = 1'b1;
          ctrl.mem_read = 1'b1;
          ctrl.wb_src   = WB_MEM;
          writes_rd     = 1'b1;
        end
      end
      OP_STORE: begin
        if (instr.s_fmt.funct3 == 3'b010) begin
          rs1            = instr.s_fmt.rs1;
          uses_rs2       = 1'b1;
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
      end
      default: ;
    endcase
    ctrl.reg_write = writes_rd && (rd != ZERO_REG);
  end

  assign rs2 = uses_rs2 ? instr.s_fmt.rs2 : ZERO_REG;

endmodule

// ==== rtl/mem_wb_stage.sv ====
`timescale 1ns/1ns

module mem_wb_stage import core_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  ex_mem_t         ex_mem,
  input  logic            store_fwd,
  input  logic [XLEN-1:0] dmem_rdata,
  output logic            dmem_en,
  output logic            dmem_we,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output wb_t             wb
);

  mem_wb_t mem_wb;

  assign dmem_en    = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);
  assign dmem_we    = ex_mem.valid && ex_mem.mem_write;
  assign dmem_addr  = ex_mem.alu_out;
  assign dmem_wdata = store_fwd ? wb.data : ex_mem.store_data;  // loaded word from MEM/WB

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.rd        <= ex_mem.rd;
      mem_wb.reg_write <= ex_mem.reg_write;
      mem_wb.wb_src    <= ex_mem.wb_src;
      mem_wb.alu_out   <= ex_mem.alu_out;
      mem_wb.load_data <= dmem_rdata;
    end
  end

  assign wb.we   = mem_wb.valid && mem_wb.reg_write;
  assign wb.addr = mem_wb.rd;
  assign wb.data = (mem_wb.wb_src == WB_MEM) ? mem_wb.load_data : mem_wb.alu_out;

  // a write strobe always comes with the enable, and never from a load
  we_needs_en: assert property (@(posedge CLK) disable iff (!rst_n)
                                dmem_we |-> dmem_en && !ex_mem.mem_read)
    else $error("mem: bad data memory strobes at %h", dmem_addr);

endmodule

// ==== rtl/riscv_core.sv ====
`timescale 1ns/1ns

module riscv_core import core_pkg::*; (
  input  logic              CLK,
  input  logic              rst_n,
  output logic [XLEN-1:0]   imem_addr,
  input  logic [XLEN-1:0]   imem_data,
  output logic              dmem_en,
  output logic              dmem_we,
  output logic [XLEN-1:0]   dmem_addr,
  output logic [XLEN-1:0]   dmem_wdata,
  input  logic [XLEN-1:0]   dmem_rdata,
  output logic [REG_AW-1:0] rf_ra1,
  output logic [REG_AW-1:0] rf_ra2,
  input  logic [XLEN-1:0]   rf_rd1,    // register file passes same-cycle writes through
  input  logic [XLEN-1:0]   rf_rd2,
  output wb_t               rf_wb
);

  instr_u            if_instr;
  logic              if_valid;
  logic              stall;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic              uses_rs2;
  id_ex_t            id_ex;
  ex_mem_t           ex_mem;
  fwd_sel_e          fwd_a;
  fwd_sel_e          fwd_b;
  logic              store_fwd;

  fetch_stage u_if (
    .CLK (CLK), .rst_n (rst_n), .stall (stall), .imem_data (imem_data),
    .imem_addr (imem_addr), .if_instr (if_instr), .if_valid (if_valid)
  );

  decode_stage u_id (
    .CLK (CLK), .rst_n (rst_n), .stall (stall), .if_instr (if_instr),
    .if_valid (if_valid), .rf_rd1 (rf_rd1), .rf_rd2 (rf_rd2), .rf_ra1 (rf_ra1),
    .rf_ra2 (rf_ra2), .rs1 (rs1), .rs2 (rs2), .uses_rs2 (uses_rs2), .id_ex (id_ex)
  );

  execute_stage u_ex (
    .CLK (CLK), .rst_n (rst_n), .id_ex (id_ex), .fwd_a (fwd_a), .fwd_b (fwd_b),
    .ex_mem_in (ex_mem), .wb (rf_wb), .ex_mem (ex_mem)
  );

  mem_wb_stage u_mem (
    .CLK (CLK), .rst_n (rst_n), .ex_mem (ex_mem), .store_fwd (store_fwd),
    .dmem_rdata (dmem_rdata), .dmem_en (dmem_en), .dmem_we (dmem_we),
    .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .wb (rf_wb)
  );

  hazard_unit u_hz (
    .rs1 (rs1), .rs2 (rs2), .uses_rs2 (uses_rs2), .id_ex (id_ex), .ex_mem (ex_mem),
    .wb (rf_wb), .stall (stall), .fwd_a (fwd_a), .fwd_b (fwd_b), .store_fwd (store_fwd)
  );

endmodule

// ==== src.f ====
rtl/core_pkg.sv
rtl/alu.sv
rtl/instr_decoder.sv
rtl/hazard_unit.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/riscv_core.sv
verification/tb_riscv_core.sv

// ==== verification/tb_riscv_core.sv ====
`timescale 1ns/1ns

module tb_riscv_core import core_pkg::*; ();

  localparam int ROM_WORDS  = 256;
  localparam int DMEM_WORDS = 256;   // 1 KB data memory
  localparam int N_SECTIONS = 4;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
  } mem_op_t;

  logic              CLK;
  logic              rst_n;
  logic [XLEN-1:0]   imem_addr;
  logic [XLEN-1:0]   imem_data;
  logic              dmem_en;
  logic              dmem_we;
  logic [XLEN-1:0]   dmem_addr;
  logic [XLEN-1:0]   dmem_wdata;
  logic [XLEN-1:0]   dmem_rdata;
  logic [REG_AW-1:0] rf_ra1;
  logic [REG_AW-1:0] rf_ra2;
  logic [XLEN-1:0]   rf_rd1;
  logic [XLEN-1:0]   rf_rd2;
  wb_t               rf_wb;

  logic [XLEN-1:0] rom [ROM_WORDS];
  logic [XLEN-1:0] dmem [DMEM_WORDS];
  logic [XLEN-1:0] regs [32];
  logic [XLEN-1:0] gold_regs [32];    // in-order reference state
  logic [XLEN-1:0] gold_mem [DMEM_WORDS];

  wb_t     exp_wr [$];
  mem_op_t exp_st [$];
  wb_t     wr_head;
  mem_op_t st_head;
  int      wr_left;
  int      st_left;

  int    sec_wr_end [N_SECTIONS];     // cumulative write count at each section end
  int    sec_st_end [N_SECTIONS];
  string sec_name [N_SECTIONS];

  logic [15:0] lfsr;
  int prog_len    = 0;
  int errors      = 0;
  int err_mark    = 0;
  int tests_run   = 0;
  int tests_done  = 0;
  int wr_done     = 0;
  int st_done     = 0;
  int cycles      = 0;
  int cycle_limit = 0;
  int clk_count   = 0;

  riscv_core uut (
    .CLK (CLK), .rst_n (rst_n), .imem_addr (imem_addr), .imem_data (imem_data),
    .dmem_en (dmem_en), .dmem_we (dmem_we), .dmem_addr (dmem_addr),
    .dmem_wdata (dmem_wdata), .dmem_rdata (dmem_rdata), .rf_ra1 (rf_ra1),
    .rf_ra2 (rf_ra2), .rf_rd1 (rf_rd1), .rf_rd2 (rf_rd2), .rf_wb (rf_wb)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  // past the program end the ROM reads as NOP
  assign imem_data  = (imem_addr[XLEN-1:2] < prog_len) ? rom[imem_addr[9:2]] : NOP_INSTR;
  assign dmem_rdata = dmem_en ? dmem[dmem_addr[9:2]] : 'x;  // drives only when enabled
  assign rf_rd1 = (rf_ra1 == ZERO_REG) ? '0 :
                  (rf_wb.we && rf_wb.addr == rf_ra1) ? rf_wb.data : regs[rf_ra1];
  assign rf_rd2 = (rf_ra2 == ZERO_REG) ? '0 :
                  (rf_wb.we && rf_wb.addr == rf_ra2) ? rf_wb.data : regs[rf_ra2];

  always @(posedge CLK) begin
    if (rf_wb.we && rf_wb.addr != ZERO_REG) regs[rf_wb.addr] <= rf_wb.data;
    if (dmem_we) dmem[dmem_addr[9:2]] <= dmem_wdata;
    clk_count <= clk_count + 1;
  end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // x^16 + x^14 + x^13 + x^11 + 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [REG_AW-1:0] pick_reg();
    logic [31:0] v;
    v = rand_bits(3);
    return (v[2:0] == 3'd0) ? 5'd7 : {2'b00, v[2:0]};   // x1 to x7
  endfunction

  function automatic logic [11:0] pick_addr();
    logic [31:0] v;
    v = rand_bits(8);
    return {2'b00, v[7:0], 2'b00};
  endfunction

  function automatic logic [XLEN-1:0] fill_word(input int idx);
    return 32'hC0DE_0000 | XLEN'(idx * 4);
  endfunction

  // kinds 0..6: add sub and or xor slt sltu
  function automatic logic [XLEN-1:0] alu_ref(input int kind, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    case (kind)
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      6:       return (a < b) ? 32'd1 : 32'd0;
      default: return a + b;
    endcase
  endfunction

  function automatic logic [2:0] kind_f3(input int kind);
    case (kind)
      2:       return 3'b111;
      3:       return 3'b110;
      4:       return 3'b100;
      5:       return 3'b010;
      6:       return 3'b011;
      default: return 3'b000;
    endcase
  endfunction

  task automatic put(input logic [XLEN-1:0] word);
    rom[8'(prog_len)] = word;
    prog_len = prog_len + 1;
  endtask

  task automatic write_reg(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] value);
    if (rd != ZERO_REG) begin          // x0 never shows up on the bus
      gold_regs[rd] = value;
      exp_wr.push_back('{we: 1'b1, addr: rd, data: value});
    end
  endtask

  task automatic emit_alu(input int kind, input logic [REG_AW-1:0] rd,
                          input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2,
                          input logic use_imm, input logic [11:0] imm);
    logic [XLEN-1:0] b;
    logic [6:0]      f7;
    b  = use_imm ? {{20{imm[11]}}, imm} : gold_regs[rs2];
    f7 = (kind == 1) ? 7'b0100000 : 7'b0000000;
    if (use_imm) put({imm, rs1, kind_f3(kind), rd, OP_IMM});
    else         put({f7, rs2, rs1, kind_f3(kind), rd, OP_REG});
    write_reg(rd, alu_ref(kind, gold_regs[rs1], b));
  endtask

  task automatic emit_lui(input logic [REG_AW-1:0] rd, input logic [19:0] imm);
    put({imm, rd, OP_LUI});
    write_reg(rd, {imm, 12'b0});
  endtask

  task automatic emit_lw(input logic [REG_AW-1:0] rd, input logic [11:0] addr);
    put({addr, ZERO_REG, 3'b010, rd, OP_LOAD});
    write_reg(rd, gold_mem[addr[9:2]]);
  endtask

  task automatic emit_sw(input logic [REG_AW-1:0] rs2, input logic [11:0] addr);
    put({addr[11:5], rs2, ZERO_REG, 3'b010, addr[4:0], OP_STORE});
    gold_mem[addr[9:2]] = gold_regs[rs2];
    exp_st.push_back('{addr: {20'h0, addr}, data: gold_regs[rs2]});
  endtask

  task automatic close_section(input int idx, input string name);
    repeat (5) put(NOP_INSTR);
    sec_wr_end[2'(idx)] = exp_wr.size();
    sec_st_end[2'(idx)] = exp_st.size();
    sec_name[2'(idx)]   = name;
  endtask

  task automatic build_program();
    int              kind;
    logic            use_imm;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] prev;
    logic [REG_AW-1:0] prev2;
    logic [REG_AW-1:0] ra;
    logic [REG_AW-1:0] rb;
    logic [11:0]     a;
    logic [31:0]     v;
    // chains where each op reads the last or the one-before result
    for (int k = 1; k < 8; k++) begin
      v = rand_bits(12);
      emit_alu(0, 5'(k), ZERO_REG, ZERO_REG, 1'b1, v[11:0]);
    end
    prev  = 5'd7;
    prev2 = 5'd6;
    repeat (24) begin
      v       = rand_bits(3);
      kind    = v % 7;
      v       = rand_bits(1);
      use_imm = v[0];
      if (use_imm && (kind == 1 || kind == 6)) kind = 0;   // no SUBI or SLTIU
      v  = rand_bits(1);
      rd = pick_reg();
      ra = v[0] ? prev : prev2;
      rb = v[0] ? prev2 : prev;
      v  = rand_bits(12);
      emit_alu(kind, rd, ra, rb, use_imm, v[11:0]);
      prev2 = prev;
      prev  = rd;
    end
    close_section(0, "arith_bypass");
    repeat (2) begin
      ra = pick_reg();
      v  = rand_bits(20);
      emit_lui(ra, v[19:0]);
      rb = pick_reg();
      v  = rand_bits(20);
      emit_lui(rb, v[19:0]);
      emit_alu(0, pick_reg(), ra, rb, 1'b0, 12'h0);
      v = rand_bits(12);
      emit_alu(0, ZERO_REG, ra, ZERO_REG, 1'b1, v[11:0]);   // result dropped
      emit_alu(0, pick_reg(), ZERO_REG, rb, 1'b0, 12'h0);
      emit_alu(3, pick_reg(), ZERO_REG, ZERO_REG, 1'b0, 12'h0);
      v = rand_bits(20);
      emit_lui(ZERO_REG, v[19:0]);
    end
    close_section(1, "lui_x0");
    repeat (4) begin
      ra = pick_reg();
      emit_lw(ra, pick_addr());
      rb = pick_reg();
      emit_alu(0, pick_reg(), ra, rb, 1'b0, 12'h0);      // rs1 waits on the load
      ra = pick_reg();
      emit_lw(ra, pick_addr());
      rb   = pick_reg();
      v    = rand_bits(3);
      kind = v % 7;
      emit_alu(kind, pick_reg(), rb, ra, 1'b0, 12'h0);   // rs2 waits on the load
      ra = pick_reg();
      emit_lw(ra, pick_addr());
      v = rand_bits(12);
      emit_alu(0, pick_reg(), ra, ZERO_REG, 1'b1, v[11:0]);
    end
    close_section(2, "load_use");
    repeat (4) begin
      a = pick_addr();
      emit_sw(pick_reg(), a);
      emit_lw(pick_reg(), a);
      ra = pick_reg();
      emit_lw(ra, pick_addr());
      a = pick_addr();
      emit_sw(ra, a);                                    // loaded word goes straight out
      emit_lw(pick_reg(), a);
    end
    close_section(3, "store_load");
  endtask

  task automatic report_test(input string name);
    $display("test %-13s %s, %0d errors", name, (errors == err_mark) ? "ok" : "failed",
             errors - err_mark);
    err_mark  = errors;
    tests_run = tests_run + 1;
  endtask

  task automatic report_drained();
    while (tests_done < N_SECTIONS && wr_done >= sec_wr_end[2'(tests_done)] &&
           st_done >= sec_st_end[2'(tests_done)]) begin
      report_test(sec_name[2'(tests_done)]);
      tests_done = tests_done + 1;
    end
  endtask

  // retire expected events in order
  always @(posedge CLK) begin
    if (rst_n) begin
      cycles = cycles + 1;
      if (rf_wb.we && exp_wr.size() > 0) begin
        void'(exp_wr.pop_front());
        wr_done = wr_done + 1;
      end
      if (dmem_we && exp_st.size() > 0) begin
        void'(exp_st.pop_front());
        st_done = st_done + 1;
      end
      wr_left = exp_wr.size();
      st_left = exp_st.size();
      wr_head = (wr_left > 0) ? exp_wr[0] : '0;
      st_head = (st_left > 0) ? exp_st[0] : '0;
    end
  end

  reset_quiet: assert property (@(posedge CLK)
      (clk_count > 0 && (!rst_n || !$past(rst_n))) |->
      (imem_addr == '0 && !rf_wb.we && !dmem_en && !dmem_we))
    else begin
      $display("[ERROR] %0t: core not idle around reset, pc %h", $time, $sampled(imem_addr));
      errors = errors + 1;
    end

  wr_order: assert property (@(posedge CLK) disable iff (!rst_n)
      rf_wb.we |-> (wr_left > 0 && rf_wb.addr == wr_head.addr && rf_wb.data == wr_head.data))
    else begin
      $display("[ERROR] %0t: register write x%0d = %h, expected x%0d = %h", $time,
               $sampled(rf_wb.addr), $sampled(rf_wb.data), $sampled(wr_head.addr),
               $sampled(wr_head.data));
      errors = errors + 1;
    end

  no_x0_write: assert property (@(posedge CLK) disable iff (!rst_n)
      rf_wb.we |-> rf_wb.addr != ZERO_REG)
    else begin
      $display("[ERROR] %0t: write strobe on register x0", $time);
      errors = errors + 1;
    end

  st_order: assert property (@(posedge CLK) disable iff (!rst_n)
      dmem_we |-> (st_left > 0 && dmem_addr == st_head.addr && dmem_wdata == st_head.data))
    else begin
      $display("[ERROR] %0t: store %h to %h, expected %h to %h", $time,
               $sampled(dmem_wdata), $sampled(dmem_addr), $sampled(st_head.data),
               $sampled(st_head.addr));
      errors = errors + 1;
    end

  initial begin
    rst_n = 1'b0;
    lfsr  = 16'd19475;
    for (int i = 0; i < 32; i++) begin
      regs[i]      <= '0;
      gold_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]     <= fill_word(i);
      gold_mem[i] = fill_word(i);
      rom[i]      = NOP_INSTR;
    end
    build_program();
    cycle_limit = 2 * prog_len + 40;
    wr_left = exp_wr.size();
    st_left = exp_st.size();
    wr_head = exp_wr[0];
    st_head = exp_st[0];
    repeat (4) @(negedge CLK);
    rst_n = 1'b1;
    @(negedge CLK);                  // first cycle out of reset has been checked
    report_test("reset");
    while (tests_done < N_SECTIONS && cycles < cycle_limit) begin
      @(negedge CLK);
      report_drained();              // sections close once their last events retired
    end
    $display("%0d of %0d tests run, %0d register writes and %0d stores retired, %0d errors",
             tests_run, N_SECTIONS + 1, wr_done, st_done, errors);
    if (tests_done < N_SECTIONS) begin
      $display("the run hung: %0d of %0d sections finished within %0d cycles",
               tests_done, N_SECTIONS, cycle_limit);
      $display("TEST RESULT: FAIL");
    end else if (errors != 0) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  end

endmodule
